// File: source/memsys_macros.svh
// word width, block geometry and memory timing shared by RTL and testbench; widths must stay 16/4/4
`ifndef MEMSYS_MACROS_SVH
`define MEMSYS_MACROS_SVH

// data and address buses are the same width
`define WORD_BITS 16

// block geometry, 16 words per block and 16 lines per cache
`define OFFSET_BITS 4
`define INDEX_BITS 4
`define TAG_BITS (`WORD_BITS - `INDEX_BITS - `OFFSET_BITS) // 8 bits left over for the tag

`define BLOCK_WORDS (1 << `OFFSET_BITS) // words in one line
`define CACHE_LINES (1 << `INDEX_BITS) // lines per cache

// main memory
`define MEM_WORDS (1 << `WORD_BITS) // full 64K word space
`define MEM_LATENCY 4 // cycles per word, the timer spans latency + 1

// initial memory image, every word holds its address xor this key
`define MEM_INIT_KEY 16'hA5C3

`endif

// File: source/bus_pkg.sv
// processor side bus types; both ports use 16-bit word addresses, no byte enables
`include "memsys_macros.svh"

package bus_pkg;

	typedef logic [`WORD_BITS-1:0] word_t; // one data word
	typedef logic [`WORD_BITS-1:0] addr_t; // word address, not byte address

	// owner of the shared fill engine
	// instruction side wins a tie
	typedef enum logic {
		REQ_IF = 1'b0, // instruction fetch port
		REQ_DM = 1'b1 // data memory port
	} requester_e;

endpackage

// File: source/cache_pkg.sv
// cache side types; address split is tag/index/offset with no byte offset bits
`include "memsys_macros.svh"

package cache_pkg;

	typedef logic [`TAG_BITS-1:0] tag_t; // upper address bits
	typedef logic [`INDEX_BITS-1:0] index_t; // selects a line
	typedef logic [`OFFSET_BITS-1:0] offset_t; // word inside a block

	// word address seen through the cache
	typedef struct packed {
		tag_t tag;
		index_t index;
		offset_t offset;
	} cache_addr_t;

	// per cycle cache operation
	typedef enum logic [1:0] {
		CACHE_READ = 2'b00, // lookup only, drives miss
		CACHE_FILL_WORD = 2'b01, // write one word from memory
		CACHE_FILL_TAG = 2'b10, // write tag and mark line valid
		CACHE_WRITE_WORD = 2'b11 // store into a line that hits
	} cache_op_e;

	// fill engine states
	typedef enum logic [2:0] {
		FS_IDLE = 3'd0,
		FS_FILL = 3'd1, // copying the block word by word
		FS_TAG = 3'd2, // one cycle tag write
		FS_STORE = 3'd3, // write-through of a store
		FS_DONE = 3'd4 // stall drops here
	} fill_state_e;

endpackage

// File: source/direct_cache.sv
// direct mapped 16x16 word cache; lookup is combinational, miss only reported for CACHE_READ
`include "memsys_macros.svh"

module direct_cache
	import bus_pkg::*;
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input addr_t addr, // word address, offset already steered by the controller
	input cache_op_e op,
	input word_t wdata, // fill word or store word
	output word_t rdata, // zero while missing
	output logic miss
);

	localparam int LINES = `CACHE_LINES;
	localparam int WORDS = `BLOCK_WORDS;

	cache_addr_t fields; // addr split into tag/index/offset
	logic [LINES-1:0] valid; // one bit per line
	tag_t tags [LINES];
	word_t data [LINES][WORDS];
	logic hit;

	assign fields = addr;

	// tag compare on the indexed line
	assign hit = valid[fields.index] && (tags[fields.index] == fields.tag);

	// fill and write ops never report a miss
	assign miss = (op == CACHE_READ) && !hit;

	assign rdata = miss ? '0 : data[fields.index][fields.offset];

	// valid bits are the only state cleared by reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else begin
			case (op)
				CACHE_FILL_WORD: valid[fields.index] <= 1'b0; // line is half old, half new
				CACHE_FILL_TAG: valid[fields.index] <= 1'b1; // block complete
				default: ;
			endcase
		end
	end

	// tag and data arrays
	always_ff @(posedge clk) begin
		case (op)
			CACHE_FILL_WORD: begin
				data[fields.index][fields.offset] <= wdata; // word from main memory
			end
			CACHE_FILL_TAG: begin
				tags[fields.index] <= fields.tag;
			end
			CACHE_WRITE_WORD: begin
				// store only lands in a resident block
				if (hit) begin
					data[fields.index][fields.offset] <= wdata;
				end
			end
			default: ; // plain lookup
		endcase
	end

endmodule

// File: source/fill_counter.sv
// word index and latency timer; one word every MEM_LATENCY + 1 cycles, start wins over run
`include "memsys_macros.svh"

module fill_counter
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start, // load timer, word index back to 0
	input logic run, // count while high
	output offset_t word_idx,
	output logic word_ready, // single cycle pulse per word
	output logic last_word // high with the pulse of word 15
);

	localparam int TIMER_BITS = $clog2(`MEM_LATENCY + 1);
	localparam logic [TIMER_BITS-1:0] TIMER_LOAD = TIMER_BITS'(`MEM_LATENCY);

	logic [TIMER_BITS-1:0] timer; // counts down to zero

	assign word_ready = run && (timer == '0);
	assign last_word = word_ready && (word_idx == '1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timer <= TIMER_LOAD; // idle
			word_idx <= '0;
		end else if (start) begin
			timer <= TIMER_LOAD;
			word_idx <= '0;
		end else if (run) begin
			if (timer == '0) begin
				timer <= TIMER_LOAD; // next word period
				word_idx <= word_idx + 1'b1; // wraps after word 15
			end else begin
				timer <= timer - 1'b1;
			end
		end
	end

endmodule

// File: source/fill_fsm.sv
// fill sequencer; expects miss and store already arbitrated for the granted port
`include "memsys_macros.svh"

module fill_fsm
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic miss, // miss of the granted port
	input logic store, // pending store, only ever for the data port
	input logic word_ready, // one word period elapsed
	input logic last_word, // word 15 is being written
	output fill_state_e state,
	output logic count_start, // reload timer, clear word index
	output logic count_run, // let the timer count
	output logic grant_lock // hold the requester choice
);

	fill_state_e next_state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FS_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state; // default hold
		case (state)
			FS_IDLE: begin
				if (miss) begin
					next_state = FS_FILL; // misses go before stores
				end else if (store) begin
					next_state = FS_STORE; // store that hits
				end
			end
			FS_FILL: begin
				if (last_word) begin
					next_state = FS_TAG;
				end
			end
			FS_TAG: begin
				// write allocate, the store follows its fill
				next_state = store ? FS_STORE : FS_DONE;
			end
			FS_STORE: begin
				if (word_ready) begin
					next_state = FS_DONE; // memory write took a full word period
				end
			end
			default: begin
				next_state = FS_IDLE; // FS_DONE and any stray code
			end
		endcase
	end

	// counter is started on every entry to FS_FILL or FS_STORE
	assign count_start = ((state == FS_IDLE) && (miss || store)) ||
		((state == FS_TAG) && store);

	assign count_run = (state == FS_FILL) || (state == FS_STORE);

	// grant is frozen through FS_DONE so the stall of that port can drop
	assign grant_lock = (state != FS_IDLE);

endmodule

// File: source/main_memory.sv
// 64K word main memory, registered read; content preset to addr ^ MEM_INIT_KEY, not reset
`include "memsys_macros.svh"

module main_memory
	import bus_pkg::*;
(
	input logic clk,
	input logic rd, // registered read enable
	input logic we,
	input addr_t addr,
	input word_t wdata,
	output word_t rdata // valid one cycle after rd
);

	localparam int DEPTH = `MEM_WORDS;

	word_t mem [DEPTH];

	// load time image, same rule the testbench shadow uses
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = word_t'(i) ^ `MEM_INIT_KEY;
		end
	end

	// write port
	always @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// read port, holds last value when rd is low
	always_ff @(posedge clk) begin
		if (rd) begin
			rdata <= mem[addr];
		end
	end

endmodule

// File: source/memory_controller.sv
// top level; IF wins ties, the other port waits on its stall, no IF write path or coherence
`include "memsys_macros.svh"

module memory_controller
	import bus_pkg::*;
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic d_enable, // low turns the data cache off
	input logic dm_we, // data port store
	input addr_t if_addr,
	input addr_t dm_addr,
	input word_t dm_wdata,
	output word_t if_rdata,
	output word_t dm_rdata,
	output logic if_stall,
	output logic dm_stall
);

	fill_state_e state;
	logic count_start, count_run, grant_lock;
	logic word_ready, last_word;
	offset_t word_idx;
	requester_e grant_next, grant_q, grant;
	logic i_miss, d_miss, d_miss_en, store_req;
	logic fsm_miss, fsm_store, fill_if, fill_dm, store_done;
	cache_op_e fill_op, i_op, d_op;
	addr_t i_cache_addr, d_cache_addr, req_addr, mem_addr;
	word_t mem_rdata, i_word, d_word, d_wdata;
	logic mem_rd, mem_we;

	assign d_miss_en = d_enable && d_miss; // disabled cache never misses
	assign store_req = d_enable && dm_we;

	// arbitration, sampled while the FSM idles
	assign grant_next = i_miss ? REQ_IF : REQ_DM;
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_q <= REQ_IF;
		end else if (!grant_lock) begin
			grant_q <= grant_next; // last idle value is what gets locked
		end
	end
	assign grant = grant_lock ? grant_q : grant_next;

	assign fsm_miss = (grant == REQ_IF) ? i_miss : d_miss_en;
	assign fsm_store = store_req && (grant == REQ_DM); // stores never ride an IF fill

	assign fill_if = grant_lock && (grant == REQ_IF);
	assign fill_dm = grant_lock && (grant == REQ_DM);

	// cache op from FSM state, writes only on the word pulse
	always_comb begin
		case (state)
			FS_FILL: fill_op = word_ready ? CACHE_FILL_WORD : CACHE_READ;
			FS_TAG: fill_op = CACHE_FILL_TAG;
			FS_STORE: fill_op = word_ready ? CACHE_WRITE_WORD : CACHE_READ;
			default: fill_op = CACHE_READ;
		endcase
	end
	assign i_op = fill_if ? fill_op : CACHE_READ; // non-granted cache just looks up
	assign d_op = fill_dm ? fill_op : CACHE_READ;

	// offset comes from the counter during a block copy
	assign i_cache_addr = (fill_if && (state == FS_FILL)) ?
		{if_addr[`WORD_BITS-1:`OFFSET_BITS], word_idx} : if_addr;
	assign d_cache_addr = (fill_dm && (state == FS_FILL)) ?
		{dm_addr[`WORD_BITS-1:`OFFSET_BITS], word_idx} : dm_addr;

	// memory side steering
	assign req_addr = (grant == REQ_IF) ? if_addr : dm_addr;
	assign mem_addr = (state == FS_STORE) ? dm_addr : // full address for the write
		{req_addr[`WORD_BITS-1:`OFFSET_BITS], word_idx}; // block base plus word
	assign mem_rd = (state == FS_FILL);
	assign mem_we = (state == FS_STORE) && word_ready; // write-through at end of the period
	assign d_wdata = (state == FS_STORE) ? dm_wdata : mem_rdata;

	// stalls are plain levels, released in FS_DONE of the owning port
	assign store_done = (state == FS_DONE) && (grant == REQ_DM);
	assign if_stall = i_miss || (fill_if && (state != FS_DONE));
	assign dm_stall = d_miss_en || (store_req && !store_done) ||
		(fill_dm && (state != FS_DONE));

	assign if_rdata = i_word;
	assign dm_rdata = d_enable ? d_word : '0;

	direct_cache i_cache (
		.clk(clk), .rst_n(rst_n), .addr(i_cache_addr), .op(i_op),
		.wdata(mem_rdata), .rdata(i_word), .miss(i_miss)
	);

	direct_cache d_cache (
		.clk(clk), .rst_n(rst_n), .addr(d_cache_addr), .op(d_op),
		.wdata(d_wdata), .rdata(d_word), .miss(d_miss)
	);

	fill_fsm u_fill_fsm (
		.clk(clk), .rst_n(rst_n), .miss(fsm_miss), .store(fsm_store),
		.word_ready(word_ready), .last_word(last_word), .state(state),
		.count_start(count_start), .count_run(count_run), .grant_lock(grant_lock)
	);

	fill_counter u_fill_counter (
		.clk(clk), .rst_n(rst_n), .start(count_start), .run(count_run),
		.word_idx(word_idx), .word_ready(word_ready), .last_word(last_word)
	);

	main_memory u_main_memory (
		.clk(clk), .rd(mem_rd), .we(mem_we), .addr(mem_addr),
		.wdata(dm_wdata), .rdata(mem_rdata)
	);

endmodule

// File: verif/tb_clock.sv
// free running clock that starts low; PERIOD should be even
module tb_clock #(
	parameter int PERIOD = 20 // time units per cycle
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk; // half period per phase
		end
	end

endmodule

// File: verif/tb_memsys.sv
// one request per port at a time; fetches stay below 0x8000 and data above, since caches are not coherent
`include "memsys_macros.svh"

module tb_memsys
	import bus_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int N_SEQ_FETCH = 64; // four blocks, cold misses then hits
	localparam int N_RAND_FETCH = 16;
	localparam int N_RAND_DATA = 40;
	localparam int N_STORE_ROUNDS = 6; // six accesses per round
	localparam int N_DUAL = 4; // two accesses per round
	localparam int N_DISABLED = 16;
	localparam int N_ACCESS = N_SEQ_FETCH + N_RAND_FETCH + N_RAND_DATA +
		6 * N_STORE_ROUNDS + 2 * N_DUAL + N_DISABLED;
	localparam int FILL_BOUND = 16 * (`MEM_LATENCY + 1) + 8; // cycles, one fill plus margin
	localparam longint WATCHDOG_TIME = longint'(N_ACCESS + 2) * FILL_BOUND * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic d_enable;
	logic dm_we;
	addr_t if_addr;
	addr_t dm_addr;
	word_t dm_wdata;
	word_t if_rdata;
	word_t dm_rdata;
	logic if_stall;
	logic dm_stall;

	logic if_active; // fetch port has a request to check
	logic dm_active; // data port has a request to check
	word_t shadow [`MEM_WORDS]; // stored words
	bit stored [`MEM_WORDS]; // word has been overwritten by a store
	logic [31:0] rng_state;
	int err_compare; // counted by the compare process
	int err_sequence; // counted by the stimulus process

	tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

	memory_controller DUT (
		.clk(clk), .rst_n(rst_n), .d_enable(d_enable), .dm_we(dm_we),
		.if_addr(if_addr), .dm_addr(dm_addr), .dm_wdata(dm_wdata),
		.if_rdata(if_rdata), .dm_rdata(dm_rdata), .if_stall(if_stall), .dm_stall(dm_stall)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// lower half of the address space
	function automatic addr_t fetch_addr(input logic [31:0] r);
		return {1'b0, r[14:0]};
	endfunction

	// upper half, only lines 0..3 so tags collide often
	function automatic addr_t data_addr(input logic [31:0] r);
		return {1'b1, r[14:8], 2'b00, r[17:16], r[3:0]};
	endfunction

	// expected read data: initial image unless a store replaced the word
	function automatic word_t expected_word(input addr_t a, input logic en);
		if (!en) begin
			return '0; // disabled data cache reads zero
		end
		return stored[a] ? shadow[a] : (a ^ `MEM_INIT_KEY);
	endfunction

	// compare at each rising edge where a port's stall is low
	always @(posedge clk) begin
		word_t expected;
		if (rst_n) begin
			if (if_active && !if_stall) begin
				expected = expected_word(if_addr, 1'b1);
				assert (if_rdata === expected) else begin
					$display("ERR %0t if_rdata expected %h actual %h", $time, expected, if_rdata);
					err_compare++;
				end
			end
			if (dm_active && !d_enable) begin
				expected = expected_word(dm_addr, 1'b0);
				assert (dm_rdata === expected) else begin
					$display("ERR %0t dm_rdata expected %h actual %h", $time, expected, dm_rdata);
					err_compare++;
				end
				assert (dm_stall === 1'b0) else begin
					$display("ERR %0t dm_stall expected 0 actual %b", $time, dm_stall);
					err_compare++;
				end
			end else if (dm_active && !dm_stall) begin
				if (dm_we) begin
					shadow[dm_addr] = dm_wdata; // store completes on this edge
					stored[dm_addr] = 1'b1;
				end
				expected = expected_word(dm_addr, 1'b1); // a store reads back at once
				assert (dm_rdata === expected) else begin
					$display("ERR %0t dm_rdata expected %h actual %h", $time, expected, dm_rdata);
					err_compare++;
				end
			end
		end
	end

	task automatic fetch(input addr_t a);
		@(negedge clk);
		if_addr = a;
		if_active = 1'b1;
		@(posedge clk);
		while (if_stall) @(posedge clk); // held until the fill is done
	endtask

	task automatic data_access(input addr_t a, input logic we, input word_t wd);
		@(negedge clk);
		d_enable = 1'b1;
		dm_addr = a;
		dm_we = we;
		dm_wdata = wd;
		dm_active = 1'b1;
		@(posedge clk);
		while (dm_stall) @(posedge clk);
		if (we) begin
			@(negedge clk);
			dm_we = 1'b0; // one store only
		end
	endtask

	// both caches miss on the same edge, fetch side must finish first
	task automatic dual_miss(input addr_t ia, input addr_t da);
		time t_if;
		time t_dm;
		@(negedge clk);
		d_enable = 1'b1;
		dm_we = 1'b0;
		if_addr = ia;
		dm_addr = da;
		if_active = 1'b1;
		dm_active = 1'b1;
		fork
			begin
				@(posedge clk);
				while (if_stall) @(posedge clk);
				t_if = $time;
			end
			begin
				@(posedge clk);
				while (dm_stall) @(posedge clk);
				t_dm = $time;
			end
		join
		assert (t_if <= t_dm) else begin
			$display("fetch stall dropped at %0t, after the data stall at %0t", t_if, t_dm);
			err_sequence++;
		end
	endtask

	task automatic disabled_access(input addr_t a, input logic we);
		@(negedge clk);
		d_enable = 1'b0;
		dm_addr = a;
		dm_we = we; // ignored while disabled
		dm_active = 1'b1;
		@(posedge clk);
	endtask

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout after %0d time units, a stall never dropped", WATCHDOG_TIME);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		addr_t a;
		addr_t b;
		word_t wd;
		logic [31:0] r;
		rng_state = 32'd2855;
		rst_n = 1'b0;
		d_enable = 1'b0;
		dm_we = 1'b0;
		if_addr = '0;
		dm_addr = '0;
		dm_wdata = '0;
		if_active = 1'b0;
		dm_active = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(posedge clk);
		// fetch port always requests, so a cold cache stalls at once
		assert (if_stall === 1'b1) else begin
			$display("ERR %0t if_stall expected 1 actual %b", $time, if_stall);
			err_sequence++;
		end
		assert (dm_stall === 1'b0) else begin
			$display("ERR %0t dm_stall expected 0 actual %b", $time, dm_stall);
			err_sequence++;
		end
		for (int k = 0; k < N_SEQ_FETCH; k++) begin
			fetch(addr_t'(k));
		end
		for (int k = 0; k < N_RAND_FETCH; k++) begin
			fetch(fetch_addr(next_rand()));
		end
		for (int k = 0; k < N_RAND_DATA; k++) begin
			data_access(data_addr(next_rand()), 1'b0, '0); // reads with tag conflicts
		end
		for (int k = 0; k < N_STORE_ROUNDS; k++) begin
			a = data_addr(next_rand());
			b = a ^ 16'h0100; // same line, other tag
			wd = word_t'(next_rand());
			data_access(a, 1'b1, wd);
			data_access(a, 1'b0, '0);
			data_access(b, 1'b0, '0); // evicts the stored block
			data_access(a, 1'b0, '0); // refill must come from memory
			data_access(a ^ 16'h0001, 1'b1, ~wd); // store hit
			data_access(a ^ 16'h0001, 1'b0, '0);
		end
		for (int k = 0; k < N_DUAL; k++) begin
			r = next_rand();
			// lines 8..11 of the data cache are still cold here
			dual_miss({8'h7E, 4'(8 + k), r[3:0]}, {8'hC3, 4'(8 + k), r[7:4]});
		end
		for (int k = 0; k < N_DISABLED; k++) begin
			r = next_rand();
			disabled_access(data_addr(r), r[31]);
		end
		@(negedge clk); // last compare has run
		$display("errors: %0d in read checks, %0d in stall and order checks",
			err_compare, err_sequence);
		if (err_compare + err_sequence == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: memsys.f
+incdir+source
source/bus_pkg.sv
source/cache_pkg.sv
source/direct_cache.sv
source/fill_counter.sv
source/fill_fsm.sv
source/main_memory.sv
source/memory_controller.sv
verif/tb_clock.sv
verif/tb_memsys.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
TOP = tb_memsys
FILELIST = memsys.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
PASS_MSG = Simulation completed successfully

SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
